/* include/conv2_rom_data.svh */
`ifndef CONV2_ROM_DATA_SVH
`define CONV2_ROM_DATA_SVH

// flat weight list, index ((o*CI + ci)*K + row)*K + col
// each line is one 3x3 kernel slice, row by row
localparam int CONV2_WEIGHT [CO*CI*K*K] = '{
    // output channel 0
     3, -1,  2,   0,  5, -4,   1,  2, -3,
    -2,  4,  1,   6, -1,  0,   3, -5,  2,
     1,  0, -3,   2,  7,  1,  -2,  4,  0,
    // output channel 1
    -4,  2,  0,   1, -1,  3,   5,  0, -2,
     0, -3,  6,   2,  1, -1,   4,  2, -6,
     7,  1, -2,  -3,  0,  5,   1, -1,  2,
    // output channel 2
     2,  2, -1,  -5,  3,  0,   0,  4,  1,
    -1,  5,  3,   0, -2,  2,  -4,  1,  3,
     4, -3,  0,   1,  2, -6,   3,  0, -1
};

// one bias per output channel
localparam int CONV2_BIAS [CO] = '{
     100,
    -250,
      37
};

`endif

/* logic/conv2_param_rom.sv */
module conv2_param_rom import conv_stage_pkg::*; (
    output weight_set_t o_weight,
    output bias_set_t   o_bias
);

`include "conv2_rom_data.svh"

    // unpack the flat lists into the tables the core reads
    always_comb begin
        for (int o = 0; o < CO; o++) begin
            for (int i = 0; i < CI; i++) begin
                for (int r = 0; r < K; r++) begin
                    for (int c = 0; c < K; c++) begin
                        o_weight.k[o].w[i][r][c] =
                            weight_t'(CONV2_WEIGHT[((o*CI + i)*K + r)*K + c]);
                    end
                end
            end
        end
    end

    always_comb begin
        for (int o = 0; o < CO; o++) begin
            o_bias.b[o] = bias_t'(CONV2_BIAS[o]);   // truncate to bias width
        end
    end

endmodule

/* logic/conv_stage_pkg.sv */
package conv_stage_pkg;

    // ============================================================
    // stage 2 geometry
    // ============================================================
    localparam int CI = 3;   // input channels
    localparam int CO = 3;   // output channels
    localparam int K  = 3;   // kernel side

    // ============================================================
    // datapath widths
    // ============================================================
    localparam int IBW     = 8;            // input pixel
    localparam int W_BW    = 8;            // weight
    localparam int B_BW    = 16;           // bias
    localparam int PROD_BW = IBW + W_BW;   // one pixel x weight product
    localparam int O_F_BW  = 22;           // 27 products + bias, no overflow

    typedef logic signed [IBW-1:0]     pixel_t;
    typedef logic signed [W_BW-1:0]    weight_t;
    typedef logic signed [B_BW-1:0]    bias_t;
    typedef logic signed [PROD_BW-1:0] prod_t;
    typedef logic signed [O_F_BW-1:0]  acc_t;

    // ============================================================
    // grouped types
    // ============================================================

    // one image position, all input channels
    typedef struct packed {
        pixel_t [CI-1:0] ch;
    } fmap_point_t;

    // K x K points, indexed pt[row][col]
    // row 0 is the oldest line, col 0 the oldest column
    typedef struct packed {
        fmap_point_t [K-1:0][K-1:0] pt;
    } window_t;

    // weights of one output channel, indexed w[ci][row][col]
    typedef struct packed {
        weight_t [CI-1:0][K-1:0][K-1:0] w;
    } kernel_t;

    typedef struct packed {
        kernel_t [CO-1:0] k;   // one kernel per output channel
    } weight_set_t;

    typedef struct packed {
        bias_t [CO-1:0] b;
    } bias_set_t;

    // one output position, all output channels
    typedef struct packed {
        acc_t [CO-1:0] ch;
    } ofmap_point_t;

endpackage

/* logic/stage2_cnn_core.sv */
module stage2_cnn_core import conv_stage_pkg::*; (
    input  logic         clk,
    input  logic         reset_n,
    input  weight_set_t  i_cnn_weight,
    input  bias_set_t    i_cnn_bias,
    input  logic         i_in_valid,
    input  window_t      i_in_window,
    output logic         o_ot_valid,
    output ofmap_point_t o_ot_fmap
);

    // ============================================================
    // stage 1: products
    // ============================================================

    // prod_q[o][ci][row][col]
    prod_t prod_q [CO][CI][K][K];
    logic  valid_s1;

    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            for (int o = 0; o < CO; o++) begin
                for (int i = 0; i < CI; i++) begin
                    for (int r = 0; r < K; r++) begin
                        for (int c = 0; c < K; c++) begin
                            // signed 8x8 gives a full 16 bit product
                            prod_q[o][i][r][c] <=
                                $signed(i_in_window.pt[r][c].ch[i]) *
                                $signed(i_cnn_weight.k[o].w[i][r][c]);
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_s1 <= 1'b0;
        end else begin
            valid_s1 <= i_in_valid;
        end
    end

    // ============================================================
    // stage 2: sum plus bias
    // ============================================================
    acc_t         sum_c [CO];
    ofmap_point_t ot_fmap_q;
    logic         valid_s2;

    always_comb begin
        for (int o = 0; o < CO; o++) begin
            sum_c[o] = acc_t'(i_cnn_bias.b[o]);   // sign extended
            for (int i = 0; i < CI; i++) begin
                for (int r = 0; r < K; r++) begin
                    for (int c = 0; c < K; c++) begin
                        sum_c[o] = sum_c[o] + acc_t'(prod_q[o][i][r][c]);
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_s1) begin
            for (int o = 0; o < CO; o++) begin
                ot_fmap_q.ch[o] <= sum_c[o];
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_s2 <= 1'b0;
        end else begin
            valid_s2 <= valid_s1;   // 2 cycles behind the window strobe
        end
    end

    assign o_ot_valid = valid_s2;
    assign o_ot_fmap  = ot_fmap_q;

endmodule

/* logic/stage2_conv.sv */
module stage2_conv import conv_stage_pkg::*; #(
    parameter int IMG_W = 5,
    parameter int IMG_H = 5
) (
    input  logic         clk,
    input  logic         reset_n,
    input  logic         i_in_valid,
    input  fmap_point_t  i_in_fmap,    // all input channels of one position
    output logic         o_ot_valid,
    output ofmap_point_t o_ot_fmap     // all output channels of one position
);

    // ============================================================
    // internal connections
    // ============================================================
    logic        win_valid;
    window_t     window;
    weight_set_t cnn_weight;   // constant levels from the rom
    bias_set_t   cnn_bias;

    // raster points into K x K windows
    window_line_buffer #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_window_line_buffer (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_in_valid  (i_in_valid),
        .i_in_fmap   (i_in_fmap),
        .o_win_valid (win_valid),
        .o_window    (window)
    );

    conv2_param_rom u_param_rom (
        .o_weight (cnn_weight),
        .o_bias   (cnn_bias)
    );

    // mac pipeline, 2 cycles
    stage2_cnn_core u_stage2_cnn_core (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_cnn_weight (cnn_weight),
        .i_cnn_bias   (cnn_bias),
        .i_in_valid   (win_valid),
        .i_in_window  (window),
        .o_ot_valid   (o_ot_valid),
        .o_ot_fmap    (o_ot_fmap)
    );

endmodule

/* logic/window_line_buffer.sv */
module window_line_buffer import conv_stage_pkg::*; #(
    parameter int IMG_W = 5,
    parameter int IMG_H = 5
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        i_in_valid,
    input  fmap_point_t i_in_fmap,
    output logic        o_win_valid,
    output window_t     o_window
);

    localparam int COL_BW = (IMG_W > 1) ? $clog2(IMG_W) : 1;
    localparam int ROW_BW = (IMG_H > 1) ? $clog2(IMG_H) : 1;

    // ============================================================
    // storage
    // ============================================================

    // line_mem[0] is the oldest row, line_mem[K-2] the previous row
    fmap_point_t line_mem [K-1][IMG_W];
    window_t     win_q;

    logic [COL_BW-1:0] col_cnt;
    logic [ROW_BW-1:0] row_cnt;
    logic              col_last;
    logic              row_last;
    logic              win_done;   // current point completes a window
    logic              win_valid_q;

    assign col_last = (col_cnt == COL_BW'(IMG_W - 1));
    assign row_last = (row_cnt == ROW_BW'(IMG_H - 1));
    assign win_done = (col_cnt >= COL_BW'(K - 1)) && (row_cnt >= ROW_BW'(K - 1));

    // ============================================================
    // raster position
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (i_in_valid) begin
            if (col_last) begin
                col_cnt <= '0;
                // wrap at end of frame so the next one can follow directly
                row_cnt <= row_last ? '0 : row_cnt + 1'b1;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            win_valid_q <= 1'b0;
        end else begin
            win_valid_q <= i_in_valid && win_done;   // one cycle after the point
        end
    end

    // ============================================================
    // window shift and row memories
    // ============================================================
    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            // shift left by one column
            for (int r = 0; r < K; r++) begin
                for (int c = 0; c < K - 1; c++) begin
                    win_q.pt[r][c] <= win_q.pt[r][c+1];
                end
            end

            // new right column, older rows from memory
            for (int r = 0; r < K - 1; r++) begin
                win_q.pt[r][K-1] <= line_mem[r][col_cnt];
            end
            win_q.pt[K-1][K-1] <= i_in_fmap;

            // push this column up one row
            for (int r = 0; r < K - 2; r++) begin
                line_mem[r][col_cnt] <= line_mem[r+1][col_cnt];
            end
            line_mem[K-2][col_cnt] <= i_in_fmap;
        end
    end

    assign o_win_valid = win_valid_q;
    assign o_window    = win_q;   // held until the next input point

endmodule

/* run.sh */
#!/bin/sh
# build and run the stage 2 convolution testbench
verilator --binary --assert -f sources.f --top-module stage2_conv_tb -o stage2_conv_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/stage2_conv_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0

/* sources.f */
+incdir+include
logic/conv_stage_pkg.sv
logic/conv2_param_rom.sv
logic/window_line_buffer.sv
logic/stage2_cnn_core.sv
logic/stage2_conv.sv
verification/stage2_conv_properties.sv
verification/stage2_conv_tb.sv

/* verification/stage2_conv_properties.sv */
module stage2_conv_properties import conv_stage_pkg::*; (
    input logic         clk,
    input logic         reset_n,
    input logic         i_win_valid,
    input logic         i_ot_valid,
    input ofmap_point_t i_ot_fmap
);

    // ============================================================
    // core pipeline checks
    // ============================================================

    // two register stages behind the window strobe
    a_latency: assert property (
        @(posedge clk) disable iff (!reset_n)
        i_ot_valid |-> $past(i_win_valid, 2)
    ) else $error("output strobe without window strobe two cycles earlier");

    a_known: assert property (
        @(posedge clk) disable iff (!reset_n)
        i_ot_valid |-> !$isunknown(i_ot_fmap)
    ) else $error("output point has unknown bits");

    // quiet while held in reset
    a_reset: assert property (
        @(posedge clk)
        !reset_n |-> !i_ot_valid
    ) else $error("output strobe during reset");

endmodule

bind stage2_cnn_core stage2_conv_properties u_properties (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_win_valid (i_in_valid),
    .i_ot_valid  (o_ot_valid),
    .i_ot_fmap   (o_ot_fmap)
);

/* verification/stage2_conv_tb.sv */
module stage2_conv_tb import conv_stage_pkg::*; ();

    localparam int    IMG_W    = 5;
    localparam int    IMG_H    = 5;
    localparam int    MAX_REC  = 128;
    localparam string VEC_FILE = "verification/stage2_conv_vectors.txt";

    logic         clk;
    logic         reset_n;
    logic         in_valid;
    fmap_point_t  in_fmap;
    logic         ot_valid;
    ofmap_point_t ot_fmap;

    // record = tag, ch2, ch1, ch0 (24 bit fields)
    logic [75:0]  vec_mem [MAX_REC];
    logic [75:0]  in_list [$];
    ofmap_point_t exp_list [$];
    ofmap_point_t exp_q [$];
    int           lat_q [$];   // drive cycle of completing points, -1 = no check

    int         cyc = 0;
    int         cyc_limit = 1000;
    int         out_count = 0;
    logic [7:0] lfsr_state;

    stage2_conv #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_in_valid (in_valid),
        .i_in_fmap  (in_fmap),
        .o_ot_valid (ot_valid),
        .o_ot_fmap  (ot_fmap)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ============================================================
    // helpers
    // ============================================================
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);   // galois, taps 8 6 5 4
    endfunction

    task automatic pick_gap(output int gap);
        logic [1:0] bits;
        for (int b = 0; b < 2; b++) begin
            lfsr_state = lfsr_step(lfsr_state);   // one step per bit
            bits[b]    = lfsr_state[0];
        end
        gap = int'(bits);
    endtask

    task automatic compare_value(input string what, input longint got, input longint expected);
        if (got !== expected) begin
            $display("ERR @%0t: %s got %0d expected %0d", $time, what, got, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_vectors();
        ofmap_point_t pt;
        for (int i = 0; i < MAX_REC; i++) begin
            if (vec_mem[i][75:72] == 4'h1) begin
                in_list.push_back(vec_mem[i]);
            end else if (vec_mem[i][75:72] == 4'h2) begin
                for (int o = 0; o < CO; o++) begin
                    pt.ch[o] = acc_t'(vec_mem[i][o*24 +: 22]);
                end
                exp_list.push_back(pt);
            end
        end
    endtask

    // one input point, then optional idle cycles
    task automatic drive_point(input logic [75:0] rec, input int idx, input bit gaps);
        int gap;
        int row;
        int col;
        col      = idx % IMG_W;
        row      = (idx / IMG_W) % IMG_H;
        in_valid = 1'b1;
        for (int c = 0; c < CI; c++) begin
            in_fmap.ch[c] = pixel_t'(rec[c*24 +: 8]);
        end
        if (row >= K - 1 && col >= K - 1) begin
            lat_q.push_back(gaps ? -1 : cyc);   // this point completes a window
        end
        @(negedge clk);
        in_valid = 1'b0;
        if (gaps) begin
            pick_gap(gap);
            repeat (gap) @(negedge clk);
        end
    endtask

    // ============================================================
    // watchdog
    // ============================================================
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= cyc_limit) begin
            $display("timeout: outputs still missing after %0d cycles", cyc);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    // ============================================================
    // output monitor
    // ============================================================
    always @(negedge clk) begin : output_monitor
        ofmap_point_t exp_pt;
        int           lat;
        if (reset_n && ot_valid) begin
            if (exp_q.size() == 0 || lat_q.size() == 0) begin
                $display("output at time %0t with no completed window behind it", $time);
                $display("Simulation finished: FAIL");
                $fatal(1, "unexpected output");
            end else begin
                exp_pt = exp_q.pop_front();
                lat    = lat_q.pop_front();
                for (int o = 0; o < CO; o++) begin
                    compare_value($sformatf("output %0d ch%0d", out_count, o),
                                  longint'($signed(ot_fmap.ch[o])),
                                  longint'($signed(exp_pt.ch[o])));
                end
                if (lat >= 0) begin
                    compare_value($sformatf("output %0d latency", out_count),
                                  longint'(cyc), longint'(lat + 3));
                end
                out_count++;
            end
        end
    end

    // ============================================================
    // stimulus
    // ============================================================
    initial begin : stimulus
        int n_in;
        int exp_total;
        in_valid   = 1'b0;
        in_fmap    = '0;
        reset_n    = 1'b0;
        lfsr_state = 8'd73;
        for (int i = 0; i < MAX_REC; i++) begin
            vec_mem[i] = {4'hf, 72'(i)};   // unused slots carry an end tag
        end
        $readmemh(VEC_FILE, vec_mem);
        load_vectors();
        n_in      = in_list.size();
        exp_total = 2 * exp_list.size();   // gapped pass plus gap-free pass
        cyc_limit = 2 * n_in * 4 + 50;

        if (n_in != 2 * IMG_W * IMG_H || exp_list.size() != 2 * (IMG_W-K+1) * (IMG_H-K+1)) begin
            $display("vectors file does not hold two complete frames");
            $display("Simulation finished: FAIL");
            $fatal(1, "bad vectors file");
        end else begin
            repeat (10) @(posedge clk);
            @(negedge clk);
            reset_n = 1'b1;

            for (int p = 0; p < 2; p++) begin
                foreach (exp_list[i]) exp_q.push_back(exp_list[i]);
            end

            // random gaps first, then back to back with latency checks
            for (int i = 0; i < n_in; i++) drive_point(in_list[i], i, 1'b1);
            for (int i = 0; i < n_in; i++) drive_point(in_list[i], i, 1'b0);

            repeat (8) @(negedge clk);   // 3 cycle pipeline plus room for stray outputs

            if (out_count != exp_total || exp_q.size() != 0) begin
                $display("got %0d outputs, expected %0d", out_count, exp_total);
                $display("Simulation finished: FAIL");
                $fatal(1, "output count");
            end else begin
                $display("Simulation finished: PASS");
                $finish;
            end
        end
    end

endmodule

/* verification/stage2_conv_vectors.txt */
// tag_ch2_ch1_ch0, each channel a 24 bit sign-extended field
// tag 1 = input point (raster order), tag 2 = expected output point
// frame 1 inputs: ch0 = 5y+x, ch1 = 10, ch2 = 4+x-y
1_000004_00000a_000000
1_000005_00000a_000001
1_000006_00000a_000002
1_000007_00000a_000003
1_000008_00000a_000004
1_000003_00000a_000005
1_000004_00000a_000006
1_000005_00000a_000007
1_000006_00000a_000008
1_000007_00000a_000009
1_000002_00000a_00000a
1_000003_00000a_00000b
1_000004_00000a_00000c
1_000005_00000a_00000d
1_000006_00000a_00000e
1_000001_00000a_00000f
1_000002_00000a_000010
1_000003_00000a_000011
1_000004_00000a_000012
1_000005_00000a_000013
1_000000_00000a_000014
1_000001_00000a_000015
1_000002_00000a_000016
1_000003_00000a_000017
1_000004_00000a_000018
// frame 1 expected outputs
2_00008c_ffff94_0000d6
2_000092_ffffa2_0000e5
2_000098_ffffb0_0000f4
2_0000aa_ffff9e_0000e5
2_0000b0_ffffac_0000f4
2_0000b6_ffffba_000103
2_0000c8_ffffa8_0000f4
2_0000ce_ffffb6_000103
2_0000d4_ffffc4_000112
// frame 2 inputs: ch0 = 50-3y, ch1 = 2x+y-6, ch2 = 7
1_000007_fffffa_000032
1_000007_fffffc_000032
1_000007_fffffe_000032
1_000007_000000_000032
1_000007_000002_000032
1_000007_fffffb_00002f
1_000007_fffffd_00002f
1_000007_ffffff_00002f
1_000007_000001_00002f
1_000007_000003_00002f
1_000007_fffffc_00002c
1_000007_fffffe_00002c
1_000007_000000_00002c
1_000007_000002_00002c
1_000007_000004_00002c
1_000007_fffffd_000029
1_000007_ffffff_000029
1_000007_000001_000029
1_000007_000003_000029
1_000007_000005_000029
1_000007_fffffe_000026
1_000007_000000_000026
1_000007_000002_000026
1_000007_000004_000026
1_000007_000006_000026
// frame 2 expected outputs
2_000137_ffffd9_00017e
2_000145_ffffe3_00018e
2_000153_ffffed_00019e
2_00012c_ffffd2_000177
2_00013a_ffffdc_000187
2_000148_ffffe6_000197
2_000121_ffffcb_000170
2_00012f_ffffd5_000180
2_00013d_ffffdf_000190
